// ==== Makefile ====
sim:
	verilator --binary --timing --assert --top-module tb_exec_unit -f build.f -o sim_exec
	./obj_dir/sim_exec > sim.log 2>&1; rc=$$?; cat sim.log; test $$rc -eq 0
	! grep -qF "*** TEST FAILED ***" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== build.f ====
verilog/rv_pkg.sv
verilog/alu.sv
verilog/rv_decode.sv
verilog/reg_file.sv
verilog/wb_exec_unit.sv
tests/exec_unit_assert.sv
tests/tb_exec_unit.sv

// ==== tests/exec_unit_assert.sv ====
`timescale 1ns/10ps

module exec_unit_assert (
    input logic            clk,
    input logic            rst_n,
    input rv_pkg::wb_req_t wb_req,
    input rv_pkg::wb_rsp_t wb_rsp
);

    logic x0_read;  // read of x0 accepted this edge

    assign x0_read = wb_req.cyc && wb_req.stb && !wb_req.we && !wb_rsp.ack &&
                     wb_req.adr == rv_pkg::adr_regs_base;

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack high for more than one cycle");

    // ack only answers a request seen one edge before
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack without a preceding cyc and stb");

    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        x0_read |=> wb_rsp.dat == 32'b0)
        else $error("read of x0 returned nonzero data");

endmodule

bind wb_exec_unit exec_unit_assert exec_unit_assert_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

// ==== tests/tb_exec_unit.sv ====
`timescale 1ns/10ps

module tb_exec_unit;

    localparam int n_alu = 200;
    localparam int n_br  = 120;
    localparam int n_ill = 20;
    localparam int n_gap = 100;
    // accesses: reset 34, regs 64, alu 6, branch 7, illegal 4, clear 3, gaps 2
    localparam int planned = 34 + 64 + 6 * n_alu + 7 * n_br + 4 * n_ill + 3 + 2 * n_gap;
    localparam int cycle_limit = 20 * planned + 100;

    logic            clk;
    logic            rst_n;
    rv_pkg::wb_req_t wb_req;
    rv_pkg::wb_rsp_t wb_rsp;

    logic [31:0] rng_state = 32'h54241a81;
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [1:0]  model_status;  // {illegal, btaken}
    int          gap_max;       // 0 = back to back
    int          n_checks;
    int          n_errors;
    int          n_issued;
    int          n_acks;
    int          cycles;

    wb_exec_unit wb_exec_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: no verdict after %0d cycles", cycle_limit);
            $display("checks %0d, errors %0d", n_checks, n_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (wb_rsp.ack === 1'b1) n_acks++;  // ack is one cycle wide
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // reference model, one instruction word against model state
    task automatic model_commit(input logic [31:0] w);
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic        lt;
        logic        ltu;
        logic        taken;
        logic [31:0] res;
        f3  = w[14:12];
        a   = model_regs[w[19:15]];
        b   = w[5] ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};  // bit 5: op or branch
        lt  = $signed(a) < $signed(b);
        ltu = a < b;
        if (w[6:0] == 7'b1100011) begin
            case (f3)
                3'd0:    taken = a == b;
                3'd1:    taken = a != b;
                3'd4:    taken = lt;
                3'd5:    taken = !lt;
                3'd6:    taken = ltu;
                default: taken = !ltu;
            endcase
            model_pc = taken ? model_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0}
                             : model_pc + 32'd4;
            model_status[0] = taken;
        end else if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011) begin
            case (f3)
                3'd0:    res = (w[30] && w[5]) ? a - b : a + b;  // no subi
                3'd1:    res = a << b[4:0];
                3'd2:    res = {31'b0, lt};
                3'd3:    res = {31'b0, ltu};
                3'd4:    res = a ^ b;
                3'd5:    res = w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6:    res = a | b;
                default: res = a & b;
            endcase
            if (w[11:7] != 5'd0) model_regs[w[11:7]] = res;
            model_pc = model_pc + 32'd4;
            model_status[0] = 1'b0;  // legal non-branch clears it
        end else begin
            model_status[1] = 1'b1;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] exp,
                                input logic [31:0] act);
        n_checks++;
        if (act !== {30'b0, exp}) begin
            n_errors++;
            $display("Mismatch %s: expected %08h, actual %08h", name, {30'b0, exp}, act);
        end
    endtask

    // one wishbone classic transfer, inputs move 1 ns after the edge
    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                              output logic [31:0] rdat);
        int gap;
        gap = gap_max > 0 ? int'(next_rand() % 32'(gap_max + 1)) : 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        n_issued++;
        do begin
            @(posedge clk);
            #1;
        end while (wb_rsp.ack !== 1'b1);
        rdat   = wb_rsp.dat;  // valid while ack high
        wb_req = '0;
    endtask

    task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
        logic [31:0] unused;
        bus_access(1'b1, rv_pkg::adr_regs_base | {1'b0, idx, 2'b00}, val, unused);
        if (idx != 5'd0) model_regs[idx] = val;
    endtask

    task automatic expect_reg(input string name, input logic [4:0] idx);
        logic [31:0] rdat;
        bus_access(1'b0, rv_pkg::adr_regs_base | {1'b0, idx, 2'b00}, 32'b0, rdat);
        check_word(name, model_regs[idx], rdat);
    endtask

    task automatic expect_state(input string name);
        logic [31:0] rdat;
        bus_access(1'b0, rv_pkg::adr_pc, 32'b0, rdat);
        check_word({name, " pc"}, model_pc, rdat);
        bus_access(1'b0, rv_pkg::adr_status, 32'b0, rdat);
        check_status({name, " status"}, model_status, rdat);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] w;
        logic [31:0] rdat;
        logic [11:0] top;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        wb_req       = '0;
        rst_n        = 1'b0;
        gap_max      = 0;
        model_pc     = 32'b0;
        model_status = 2'b00;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        expect_state("reset");
        for (int i = 0; i < 32; i++)
            expect_reg("reset reg", 5'(i));

        for (int i = 0; i < 32; i++)
            set_reg(5'(i), next_rand());  // x0 write is dropped
        for (int i = 0; i < 32; i++)
            expect_reg("reg rw", 5'(i));

        // op and op-imm, rs1/rs2/rd/f3 straight from r
        for (int n = 0; n < n_alu; n++) begin
            r  = next_rand();
            va = next_rand();
            vb = r[1:0] == 2'b00 ? va : next_rand();  // some equal pairs for compares
            set_reg(r[19:15], va);
            set_reg(r[24:20], vb);
            f3  = r[14:12];
            top = r[31:20];
            if (f3 == 3'd1) top = {7'b0, r[24:20]};               // slli
            if (f3 == 3'd5) top = {1'b0, r[30], 5'b0, r[24:20]};  // srli / srai
            if (r[2]) top = {1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, r[24:20]};
            w = {top, r[19:15], f3, r[11:7], r[2] ? 7'b0110011 : 7'b0010011};
            bus_access(1'b1, rv_pkg::adr_instr, w, rdat);
            model_commit(w);
            expect_reg("alu rd", r[11:7]);
            expect_state("alu");
        end

        // branches on equal, smaller and larger pairs
        for (int n = 0; n < n_br; n++) begin
            r   = next_rand();
            va  = next_rand();
            vb  = (next_rand() & 32'hff) + 32'd1;
            vb  = r[1:0] == 2'b00 ? va : (r[0] ? va + vb : va - vb);
            rs1 = 5'd1 + {1'b0, r[18:15]};   // 1..16
            rs2 = 5'd16 + {1'b0, r[23:20]};  // 16..31
            set_reg(rs1, va);
            set_reg(rs2, vb);
            f3 = r[14:12];
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // unused codes become bltu/bgeu
            w = {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
            bus_access(1'b1, rv_pkg::adr_instr, w, rdat);
            model_commit(w);
            expect_state("branch");
            expect_reg("branch rs1", rs1);
            expect_reg("branch rs2", rs2);
        end

        for (int n = 0; n < n_ill; n++) begin
            w = next_rand();
            if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011 || w[6:0] == 7'b1100011)
                w[2] = ~w[2];  // lands on lui, auipc or jalr
            bus_access(1'b1, rv_pkg::adr_instr, w, rdat);
            model_commit(w);
            expect_state("illegal");
            expect_reg("illegal reg", w[11:7]);
        end
        bus_access(1'b1, rv_pkg::adr_status, 32'b0, rdat);  // clears sticky flag
        model_status = 2'b00;
        expect_state("status clear");

        gap_max = 3;
        for (int n = 0; n < n_gap; n++) begin
            r = next_rand();
            set_reg(r[4:0], next_rand());
            expect_reg("gap reg", r[4:0]);
        end
        gap_max = 0;
        @(posedge clk);
        #1;
        check_word("ack count", 32'(n_issued), 32'(n_acks));

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic            bneq,
    input  logic            btype,
    input  rv_pkg::alu_fn_e alu_fn,
    input  logic [31:0]     operand_a,
    input  logic [31:0]     operand_b,
    output logic            btaken,
    output logic [31:0]     result
);

    logic [3:0] fn;           // raw code bits for the cheap decode
    logic       sub_op;
    logic       sll_op;
    logic       sra_op;
    logic       signed_cmp;

    assign fn     = alu_fn;
    assign sub_op = fn[3];               // also hits sra/bge/bgeu, result mux ignores those
    assign sll_op = ~fn[3] & ~fn[2];     // add/slt/sltu also match, harmless
    assign sra_op = fn[3] & fn[2];
    // slt or bge take the signed compare
    assign signed_cmp = (~fn[3] & fn[1] & ~fn[0]) | (fn[3] & fn[0]);

    // adder, invert b and carry in for sub
    logic [31:0] b_add;
    logic [31:0] sum;

    assign b_add = operand_b ^ {32{sub_op}};
    assign sum   = operand_a + b_add + {31'b0, sub_op};

    // single right shifter, sll via bit reversal around it
    logic [4:0]         shamt;
    logic [31:0]        a_rev;
    logic [31:0]        shift_in;
    logic signed [32:0] shift_ext;  // extra msb carries the sra fill
    logic [32:0]        shift_full;
    logic [31:0]        shift_out;
    logic [31:0]        shift_rev;
    logic [31:0]        shifter_result;

    assign shamt      = operand_b[4:0];       // rv32 only looks at 5 bits
    assign a_rev      = {<<{operand_a}};
    assign shift_in   = sll_op ? a_rev : operand_a;
    assign shift_ext  = {sra_op & shift_in[31], shift_in};
    assign shift_full = shift_ext >>> shamt;
    assign shift_out  = shift_full[31:0];
    assign shift_rev  = {<<{shift_out}};
    assign shifter_result = sll_op ? shift_rev : shift_out;

    // one comparator for signed and unsigned
    logic less;

    assign less = signed_cmp ? ($signed(operand_a) < $signed(operand_b))
                             : (operand_a < operand_b);

    // result select
    always_comb begin
        case (alu_fn)
            rv_pkg::alu_and:  result = operand_a & operand_b;
            rv_pkg::alu_or:   result = operand_a | operand_b;
            rv_pkg::alu_xor:  result = operand_a ^ operand_b;
            rv_pkg::alu_add,
            rv_pkg::alu_sub:  result = sum;
            rv_pkg::alu_sll,
            rv_pkg::alu_srl,
            rv_pkg::alu_sra:  result = shifter_result;
            rv_pkg::alu_slt,
            rv_pkg::alu_sltu,
            rv_pkg::alu_bge,
            rv_pkg::alu_bgeu: result = {31'b0, less};
            default:          result = 32'b0;
        endcase
    end

    // branch decision, only for branch instructions
    always_comb begin
        btaken = 1'b0;
        if (btype) begin
            case (alu_fn)
                rv_pkg::alu_sub:  btaken = bneq ? (|result) : ~(|result);  // bne / beq
                rv_pkg::alu_slt,
                rv_pkg::alu_sltu: btaken = result[0];
                rv_pkg::alu_bge,
                rv_pkg::alu_bgeu: btaken = ~result[0];  // not less
                default:          btaken = 1'b0;
            endcase
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/10ps

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd
);

    localparam int idx_w = $clog2(num_regs);

    logic [31:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (we && wa != 5'd0 && int'(wa) < num_regs) begin  // x0 never written
            regs[wa[idx_w-1:0]] <= wd;
        end
    end

    // x0 and out of range indices read zero
    assign rd1 = (ra1 != 5'd0 && int'(ra1) < num_regs) ? regs[ra1[idx_w-1:0]] : 32'b0;
    assign rd2 = (ra2 != 5'd0 && int'(ra2) < num_regs) ? regs[ra2[idx_w-1:0]] : 32'b0;

endmodule

// ==== verilog/rv_decode.sv ====
`timescale 1ns/10ps

module rv_decode #(
    parameter int num_regs = 32
) (
    input  logic [31:0]  instr,
    output rv_pkg::dec_t dec
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic        bad_rs1;
    logic        bad_rs2;
    logic        bad_rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // indices past the register count, only matters for rv32e
    assign bad_rs1 = int'(instr[19:15]) >= num_regs;
    assign bad_rs2 = int'(instr[24:20]) >= num_regs;
    assign bad_rd  = int'(instr[11:7]) >= num_regs;

    always_comb begin
        dec         = '0;
        dec.alu_fn  = rv_pkg::alu_add;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        dec.imm     = imm_i;
        dec.illegal = 1'b1;  // until an opcode claims it
        case (opcode)
            opc_op: begin
                dec.rd_we  = 1'b1;
                dec.alu_fn = rv_pkg::alu_fn_e'({instr[30], funct3});  // bit 30 -> sub / sra
                // funct7 0100000 only legal for sub and sra
                dec.illegal = !((funct7 == 7'b0000000) ||
                                (funct7 == 7'b0100000 && (funct3 == 3'b000 ||
                                                          funct3 == 3'b101)))
                              || bad_rs1 || bad_rs2 || bad_rd;
            end
            opc_op_imm: begin
                dec.rd_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_fn  = rv_pkg::alu_fn_e'({instr[30] && funct3 == 3'b101, funct3});
                dec.illegal = bad_rs1 || bad_rd;
                if (funct3 == 3'b001) begin                 // slli
                    dec.imm = {27'b0, instr[24:20]};
                    if (funct7 != 7'b0000000) dec.illegal = 1'b1;
                end else if (funct3 == 3'b101) begin        // srli / srai
                    dec.imm = {27'b0, instr[24:20]};
                    if (funct7 != 7'b0000000 && funct7 != 7'b0100000) dec.illegal = 1'b1;
                end
            end
            opc_branch: begin
                dec.btype   = 1'b1;
                dec.imm     = imm_b;
                dec.illegal = bad_rs1 || bad_rs2;
                case (funct3)
                    3'b000:  dec.alu_fn = rv_pkg::alu_sub;   // beq
                    3'b001: begin                            // bne
                        dec.alu_fn = rv_pkg::alu_sub;
                        dec.bneq   = 1'b1;
                    end
                    3'b100:  dec.alu_fn = rv_pkg::alu_slt;   // blt
                    3'b101:  dec.alu_fn = rv_pkg::alu_bge;
                    3'b110:  dec.alu_fn = rv_pkg::alu_sltu;  // bltu
                    3'b111:  dec.alu_fn = rv_pkg::alu_bgeu;
                    default: dec.illegal = 1'b1;             // 010, 011 unused
                endcase
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // alu function codes
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sll  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_xor  = 4'd4,
        alu_srl  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_sub  = 4'd8,
        alu_bge  = 4'd9,
        alu_bgeu = 4'd10,
        alu_sra  = 4'd13
    } alu_fn_e;

    // one decoded instruction from decode to top
    typedef struct packed {
        alu_fn_e     alu_fn;
        logic        use_imm;  // operand b from imm
        logic [31:0] imm;      // i-imm or b-imm on branches
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        rd_we;
        logic        btype;    // conditional branch
        logic        bneq;     // bne rather than beq
        logic        illegal;
    } dec_t;

    // wishbone classic request from the host
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;      // byte address
        logic [31:0] dat;
    } wb_req_t;

    // wishbone classic response from the slave
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // slave address map
    localparam logic [7:0] adr_instr     = 8'h00;  // write executes
    localparam logic [7:0] adr_pc        = 8'h04;
    localparam logic [7:0] adr_status    = 8'h08;  // bit0 btaken, bit1 illegal
    localparam logic [7:0] adr_regs_base = 8'h80;  // x[n] at base + 4n

endpackage

// ==== verilog/wb_exec_unit.sv ====
`timescale 1ns/10ps

module wb_exec_unit #(
    parameter int          num_regs = 32,
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::wb_req_t wb_req,
    output rv_pkg::wb_rsp_t wb_rsp
);

    logic        ack;
    logic [31:0] rd_dat;     // registered read data
    logic [31:0] pc;
    logic [1:0]  status;     // {illegal sticky, last btaken}

    logic        access;
    logic        wr;
    logic        is_instr;
    logic        is_pc;
    logic        is_status;
    logic        is_reg;
    logic [4:0]  reg_idx;

    rv_pkg::dec_t dec;
    logic [4:0]   ra1;
    logic [31:0]  rd1;
    logic [31:0]  rd2;
    logic [31:0]  op_b;
    logic [31:0]  alu_result;
    logic         btaken;
    logic         commit;    // legal instruction write accepted
    logic         rf_we;

    // new access: cyc & stb seen while ack still low
    assign access = wb_req.cyc & wb_req.stb & ~ack;
    assign wr     = access & wb_req.we;

    // address decode
    assign is_instr  = wb_req.adr == rv_pkg::adr_instr;
    assign is_pc     = wb_req.adr == rv_pkg::adr_pc;
    assign is_status = wb_req.adr == rv_pkg::adr_status;
    assign is_reg    = wb_req.adr[7] && wb_req.adr[1:0] == 2'b00;  // 0x80..0xfc, aligned
    assign reg_idx   = wb_req.adr[6:2];

    rv_decode #(.num_regs(num_regs)) rv_decode_i (
        .instr (wb_req.dat),
        .dec   (dec)
    );

    assign ra1  = is_reg ? reg_idx : dec.rs1;   // host reads share port 1
    assign op_b = dec.use_imm ? dec.imm : rd2;

    alu alu_i (
        .bneq      (dec.bneq),
        .btype     (dec.btype),
        .alu_fn    (dec.alu_fn),
        .operand_a (rd1),
        .operand_b (op_b),
        .btaken    (btaken),
        .result    (alu_result)
    );

    assign commit = wr & is_instr & ~dec.illegal;
    assign rf_we  = (wr & is_reg) | (commit & dec.rd_we);  // host write or writeback

    reg_file #(.num_regs(num_regs)) reg_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (ra1),
        .ra2   (dec.rs2),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (rf_we),
        .wa    (is_reg ? reg_idx : dec.rd),
        .wd    (is_reg ? wb_req.dat : alu_result)
    );

    // ack, pc and status
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack    <= 1'b0;
            pc     <= reset_pc;
            status <= 2'b00;
        end else begin
            ack <= access;                       // one cycle, access drops while ack high
            if (wr && is_pc) pc <= wb_req.dat;
            if (wr && is_status) status <= 2'b00;
            if (commit) begin
                pc        <= btaken ? pc + dec.imm : pc + 32'd4;
                status[0] <= btaken;
            end
            if (wr && is_instr && dec.illegal) status[1] <= 1'b1;  // sticky
        end
    end

    // read data captured at the accepting edge
    always_ff @(posedge clk) begin
        if (access && !wb_req.we) begin
            if (is_pc)          rd_dat <= pc;
            else if (is_status) rd_dat <= {30'b0, status};
            else if (is_reg)    rd_dat <= rd1;
            else                rd_dat <= 32'b0;   // instr and unmapped
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

endmodule
